/* Makefile */
TOP  := tb_commit_top
SRCS := $(filter-out +%,$(shell cat project.f)) commit_config.svh

.PHONY: all lint clean

# build, run, pass only when the testbench printed its pass line
all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep '^PASS: all tests$$' > /dev/null

obj_dir/V$(TOP): project.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f project.f

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir

/* cdb_if.sv */
`include "commit_config.svh"

// completion bus, one slot per functional unit result
interface cdb_if;
	import commit_pkg::*;

	// slot carries a result this cycle
	logic [`COMMIT_WAYS-1:0] valid;

	// reorder buffer entry being completed
	rob_tag_t [`COMMIT_WAYS-1:0] rob_tag;

	// result written into the entry
	word_t [`COMMIT_WAYS-1:0] value;

	// entry is a halt instruction
	logic [`COMMIT_WAYS-1:0] halt;

	// top level drives the bus
	modport source (
		output valid, rob_tag, value, halt
	);

	// reorder buffer listens
	modport sink (
		input valid, rob_tag, value, halt
	);

endinterface

/* commit_cases.txt */
# count, then dest value halt for each instruction, then the completion order
# every field is hex, the completion order lists instruction numbers from 0
3  1 a001 0  2 a002 0  3 a003 0  0 1 2
3  4 b004 0  5 b005 0  6 b006 0  2 1 0
4  7 c0000001 0  7 c0000002 0  7 c0000003 0  8 c0000004 0  3 0 2 1
3  0 d0000000 0  9 d0000009 0  0 d000000f 0  1 2 0
5  a 1111 0  b 2222 0  a 3333 0  0 4444 0  b 5555 0  4 3 2 1 0
4  c 0badf00d 0  d 0 1  e e00e 0  f f00f 0  2 3 0 1
3  10 1010 1  11 1111 0  12 1212 0  0 1 2
6  13 13 0  14 14 0  15 15 0  16 16 1  17 17 0  18 18 0  5 4 3 2 1 0
3  0 ff01 0  0 ff02 0  0 ff03 0  1 0 2
7  19 71 0  1a 72 0  19 73 0  1b 74 0  1b 75 0  1c 76 0  1c 77 0  6 5 4 3 2 1 0
8  1 81 0  2 82 0  3 83 0  4 84 0  5 85 0  6 86 0  7 87 0  8 88 0  7 6 5 4 3 2 1 0
a  1 11 0 2 12 0 3 13 0 4 14 0 5 15 0 6 16 0 7 17 0 8 18 0 9 19 0 a 1a 0  0 1 2 3 4 5 6 7 8 9
a  b 21 0 c 22 0 d 23 0 e 24 0 f 25 0 10 26 0 11 27 0 12 28 0 13 29 0 14 2a 0  2 0 1 5 3 4 7 6 9 8
9  1 31 0 1 32 0 2 33 0 2 34 0 1 35 0 0 36 0 3 37 0 3 38 0 3 39 0  1 0 3 2 5 4 8 7 6

/* commit_config.svh */
`ifndef COMMIT_CONFIG_SVH
`define COMMIT_CONFIG_SVH

// slots per cycle at dispatch, completion and retire
`define COMMIT_WAYS 3

// reorder buffer entries, keep a power of two so tags wrap for free
`define ROB_SIZE 8

// architectural register file
`define ARCH_REGS 32

// hard-wired zero register, writes to it are dropped
`define ZERO_REG 0

// data and program counter width
`define XLEN 32

`endif

/* commit_pkg.sv */
`include "commit_config.svh"

package commit_pkg;

	////////////////////////////////////////////////////////////////////////////
	// index types
	////////////////////////////////////////////////////////////////////////////

	// entry index into the reorder buffer
	typedef logic [$clog2(`ROB_SIZE)-1:0] rob_tag_t;

	// architectural register number
	typedef logic [$clog2(`ARCH_REGS)-1:0] reg_idx_t;

	////////////////////////////////////////////////////////////////////////////
	// payload and count types
	////////////////////////////////////////////////////////////////////////////

	// result value or next pc
	typedef logic [`XLEN-1:0] word_t;

	// number of slots in a group, 0 up to the machine width
	typedef logic [$clog2(`COMMIT_WAYS+1)-1:0] slot_cnt_t;

	////////////////////////////////////////////////////////////////////////////
	// machine status
	////////////////////////////////////////////////////////////////////////////

	// sticky once a halt has retired
	typedef enum logic {
		no_error      = 1'b0,
		halted_on_wfi = 1'b1
	} commit_status_t;

endpackage

/* commit_top.sv */
`include "commit_config.svh"

module commit_top (
	input  logic                                     clock,
	input  logic                                     reset,
	// dispatch group
	input  logic [`COMMIT_WAYS-1:0]                  dispatch_valid,
	input  commit_pkg::reg_idx_t [`COMMIT_WAYS-1:0]  dispatch_dest,
	input  commit_pkg::word_t [`COMMIT_WAYS-1:0]     dispatch_npc,
	output commit_pkg::slot_cnt_t                    dispatch_num,
	output commit_pkg::rob_tag_t [`COMMIT_WAYS-1:0]  dispatch_tag,
	// completion bus
	input  logic [`COMMIT_WAYS-1:0]                  complete_valid,
	input  commit_pkg::rob_tag_t [`COMMIT_WAYS-1:0]  complete_tag,
	input  commit_pkg::word_t [`COMMIT_WAYS-1:0]     complete_value,
	input  logic [`COMMIT_WAYS-1:0]                  complete_halt,
	// register file commit
	output logic [`COMMIT_WAYS-1:0]                  commit_wr_en,
	output commit_pkg::reg_idx_t [`COMMIT_WAYS-1:0]  commit_wr_idx,
	output commit_pkg::word_t [`COMMIT_WAYS-1:0]     commit_wr_data,
	output commit_pkg::word_t [`COMMIT_WAYS-1:0]     commit_npc,
	output logic [`COMMIT_WAYS-1:0]                  commit_valid,
	output commit_pkg::commit_status_t               error_status
);

	cdb_if    cdb ();
	retire_if rt ();

	// plain completion ports onto the bus
	assign cdb.valid   = complete_valid;
	assign cdb.rob_tag = complete_tag;
	assign cdb.value   = complete_value;
	assign cdb.halt    = complete_halt;

	reorder_buffer i_reorder_buffer (
		.clock          (clock),
		.reset          (reset),
		.dispatch_valid (dispatch_valid),
		.dispatch_dest  (dispatch_dest),
		.dispatch_npc   (dispatch_npc),
		.dispatch_num   (dispatch_num),
		.dispatch_tag   (dispatch_tag),
		.cdb            (cdb.sink),
		.retire         (rt.rob)
	);

	retire_stage i_retire_stage (
		.clock          (clock),
		.reset          (reset),
		.retire         (rt.retire),
		.commit_wr_en   (commit_wr_en),
		.commit_wr_idx  (commit_wr_idx),
		.commit_wr_data (commit_wr_data),
		.commit_npc     (commit_npc),
		.commit_valid   (commit_valid),
		.error_status   (error_status)
	);

endmodule

/* project.f */
+incdir+.
commit_pkg.sv
cdb_if.sv
retire_if.sv
reorder_buffer.sv
retire_stage.sv
commit_top.sv
tb_commit_top.sv

/* reorder_buffer.sv */
`include "commit_config.svh"

module reorder_buffer (
	input  logic                                     clock,
	input  logic                                     reset,
	input  logic [`COMMIT_WAYS-1:0]                  dispatch_valid,
	input  commit_pkg::reg_idx_t [`COMMIT_WAYS-1:0]  dispatch_dest,
	input  commit_pkg::word_t [`COMMIT_WAYS-1:0]     dispatch_npc,
	output commit_pkg::slot_cnt_t                    dispatch_num,
	output commit_pkg::rob_tag_t [`COMMIT_WAYS-1:0]  dispatch_tag,
	cdb_if.sink                                      cdb,
	retire_if.rob                                    retire
);
	import commit_pkg::*;

	// occupancy needs one bit more than a tag, 0 up to ROB_SIZE
	typedef logic [$clog2(`ROB_SIZE):0] occ_t;

	// pointers and occupancy
	rob_tag_t head;
	rob_tag_t tail;
	occ_t     count;

	// set by a retiring halt, blocks all further retirement
	logic stopped;

	// per entry state
	logic [`ROB_SIZE-1:0] done_q;
	logic [`ROB_SIZE-1:0] halt_q;
	reg_idx_t             dest_q [`ROB_SIZE];
	word_t                npc_q [`ROB_SIZE];
	word_t                value_q [`ROB_SIZE];

	// dispatch side
	slot_cnt_t                   req_num;
	occ_t                        free_num;
	logic [`COMMIT_WAYS-1:0]     alloc_en;

	// retire side
	rob_tag_t [`COMMIT_WAYS-1:0] ret_idx;
	slot_cnt_t                   retire_num;
	logic                        retire_go;
	logic                        halt_retire;

	////////////////////////////////////////////////////////////////////////////
	// dispatch, take min(requested, free) from slot 0 up
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		req_num = '0;
		// mask is contiguous, so a popcount is the request size
		for (int i = 0; i < `COMMIT_WAYS; i++) begin
			if (dispatch_valid[i])
				req_num = req_num + slot_cnt_t'(1);
		end
		free_num = occ_t'(`ROB_SIZE) - count;
		if (occ_t'(req_num) < free_num)
			dispatch_num = req_num;
		else
			dispatch_num = slot_cnt_t'(free_num);
		// tags are consecutive from the tail
		for (int i = 0; i < `COMMIT_WAYS; i++) begin
			dispatch_tag[i] = tail + rob_tag_t'(i);
			alloc_en[i]     = i < int'(dispatch_num);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// retire, leading done entries at the head
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		retire_num  = '0;
		halt_retire = 1'b0;
		retire_go   = !stopped;
		for (int i = 0; i < `COMMIT_WAYS; i++) begin
			ret_idx[i] = head + rob_tag_t'(i);
			// stop at the first empty or unfinished entry
			retire_go = retire_go && (i < int'(count)) && done_q[ret_idx[i]];
			retire.valid[i]    = retire_go;
			retire.dest_reg[i] = dest_q[ret_idx[i]];
			retire.value[i]    = value_q[ret_idx[i]];
			retire.npc[i]      = npc_q[ret_idx[i]];
			retire.halt[i]     = halt_q[ret_idx[i]];
			if (retire_go) begin
				retire_num = retire_num + slot_cnt_t'(1);
				// a halt closes the group, younger slots stay put
				if (halt_q[ret_idx[i]]) begin
					halt_retire = 1'b1;
					retire_go   = 1'b0;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// control state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			head    <= '0;
			tail    <= '0;
			count   <= '0;
			stopped <= 1'b0;
			done_q  <= '0;
		end else begin
			head  <= head + rob_tag_t'(retire_num);
			tail  <= tail + rob_tag_t'(dispatch_num);
			count <= count + occ_t'(dispatch_num) - occ_t'(retire_num);
			if (halt_retire)
				stopped <= 1'b1;
			// fresh entries start unfinished
			for (int i = 0; i < `COMMIT_WAYS; i++) begin
				if (alloc_en[i])
					done_q[dispatch_tag[i]] <= 1'b0;
			end
			// completions never hit an entry allocated this cycle
			for (int i = 0; i < `COMMIT_WAYS; i++) begin
				if (cdb.valid[i])
					done_q[cdb.rob_tag[i]] <= 1'b1;
			end
		end
	end

	// entry payload, written at allocate and at completion
	always_ff @(posedge clock) begin
		for (int i = 0; i < `COMMIT_WAYS; i++) begin
			if (alloc_en[i]) begin
				dest_q[dispatch_tag[i]] <= dispatch_dest[i];
				npc_q[dispatch_tag[i]]  <= dispatch_npc[i];
			end
			if (cdb.valid[i]) begin
				value_q[cdb.rob_tag[i]] <= cdb.value[i];
				halt_q[cdb.rob_tag[i]]  <= cdb.halt[i];
			end
		end
	end

endmodule

/* retire_if.sv */
`include "commit_config.svh"

// retire group from the head of the reorder buffer
// slot 0 is the oldest, valid slots are packed from slot 0
interface retire_if;
	import commit_pkg::*;

	// slot retires this cycle
	logic [`COMMIT_WAYS-1:0] valid;

	// destination register of the retiring entry
	reg_idx_t [`COMMIT_WAYS-1:0] dest_reg;

	// completed result
	word_t [`COMMIT_WAYS-1:0] value;

	// next pc recorded at dispatch
	word_t [`COMMIT_WAYS-1:0] npc;

	// retiring entry is a halt
	logic [`COMMIT_WAYS-1:0] halt;

	// buffer side, combinational from its state
	modport rob (
		output valid, dest_reg, value, npc, halt
	);

	// retire stage side
	modport retire (
		input valid, dest_reg, value, npc, halt
	);

endinterface

/* retire_stage.sv */
`include "commit_config.svh"

module retire_stage (
	input  logic                                    clock,
	input  logic                                    reset,
	retire_if.retire                                retire,
	output logic [`COMMIT_WAYS-1:0]                 commit_wr_en,
	output commit_pkg::reg_idx_t [`COMMIT_WAYS-1:0] commit_wr_idx,
	output commit_pkg::word_t [`COMMIT_WAYS-1:0]    commit_wr_data,
	output commit_pkg::word_t [`COMMIT_WAYS-1:0]    commit_npc,
	output logic [`COMMIT_WAYS-1:0]                 commit_valid,
	output commit_pkg::commit_status_t              error_status
);
	import commit_pkg::*;

	// write enables before the output register
	logic [`COMMIT_WAYS-1:0] wr_en_next;
	// some valid slot of this group is a halt
	logic                    halt_seen;

	////////////////////////////////////////////////////////////////////////////
	// write suppression
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < `COMMIT_WAYS; i++) begin
			// never write the zero register
			wr_en_next[i] = retire.valid[i] && (retire.dest_reg[i] != reg_idx_t'(`ZERO_REG));
			// youngest writer of a register wins inside the group
			for (int j = i + 1; j < `COMMIT_WAYS; j++) begin
				if (retire.valid[j] && (retire.dest_reg[j] == retire.dest_reg[i]))
					wr_en_next[i] = 1'b0;
			end
		end
		halt_seen = |(retire.valid & retire.halt);
	end

	////////////////////////////////////////////////////////////////////////////
	// commit outputs, one cycle after the group
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			commit_wr_en <= '0;
			commit_valid <= '0;
			error_status <= no_error;
		end else begin
			commit_wr_en <= wr_en_next;
			commit_valid <= retire.valid;
			// sticky until reset
			if (halt_seen)
				error_status <= halted_on_wfi;
		end
	end

	// payload follows the strobes
	always_ff @(posedge clock) begin
		commit_wr_idx  <= retire.dest_reg;
		commit_wr_data <= retire.value;
		commit_npc     <= retire.npc;
	end

endmodule

/* tb_commit_top.sv */
`include "commit_config.svh"

module tb_commit_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int W     = `COMMIT_WAYS;
	localparam int RW    = $clog2(`ARCH_REGS);
	localparam int TW    = $clog2(`ROB_SIZE);
	localparam int CW    = $clog2(`COMMIT_WAYS + 1);
	localparam int MAXN  = 16;
	localparam int LIMIT = 600;

	logic                    clock;
	logic                    reset;
	logic [W-1:0]            dispatch_valid;
	logic [W-1:0][RW-1:0]    dispatch_dest;
	logic [W-1:0][`XLEN-1:0] dispatch_npc;
	logic [CW-1:0]           dispatch_num;
	logic [W-1:0][TW-1:0]    dispatch_tag;
	logic [W-1:0]            complete_valid;
	logic [W-1:0][TW-1:0]    complete_tag;
	logic [W-1:0][`XLEN-1:0] complete_value;
	logic [W-1:0]            complete_halt;
	logic [W-1:0]            commit_wr_en;
	logic [W-1:0][RW-1:0]    commit_wr_idx;
	logic [W-1:0][`XLEN-1:0] commit_wr_data;
	logic [W-1:0][`XLEN-1:0] commit_npc;
	logic [W-1:0]            commit_valid;
	logic                    error_status;

	// run bookkeeping
	int fd;
	int errors;
	int failed;
	int tests;
	int case_id;
	bit aborted;

	// current case in program order
	int               n;
	int               expected;
	int               committed;
	bit               halted;
	logic [RW-1:0]    dest [MAXN];
	logic [`XLEN-1:0] val [MAXN];
	logic             hlt [MAXN];
	int               order [MAXN];
	logic [TW-1:0]    tag [MAXN];

	commit_top i_commit_top (.*);

	always #20 clock = ~clock;

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// npc unique per case and instruction
	function automatic logic [31:0] npc_of(int i);
		return 32'h1000 + 32'(case_id) * 32'h100 + 32'(i + 1) * 32'd4;
	endfunction

	task automatic drive_idle();
		dispatch_valid = '0;
		dispatch_dest  = '0;
		dispatch_npc   = '0;
		complete_valid = '0;
		complete_tag   = '0;
		complete_value = '0;
		complete_halt  = '0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// case file reader that skips # lines
	////////////////////////////////////////////////////////////////////////////

	task automatic read_value(output int v, output bit ok);
		string tok;
		string rest;
		int    rc;
		bit    searching;
		ok = 1'b0;
		v = 0;
		searching = 1'b1;
		while (searching) begin
			rc = $fscanf(fd, "%s", tok);
			if (rc != 1)
				searching = 1'b0;
			else if (tok.substr(0, 0) == "#")
				rc = $fgets(rest, fd);
			else begin
				v = tok.atohex();
				ok = 1'b1;
				searching = 1'b0;
			end
		end
	endtask

	task automatic load_case(output bit got_case);
		int v;
		bit ok;
		bit all_ok;
		read_value(v, got_case);
		all_ok = 1'b1;
		if (got_case && (v < 1 || v > MAXN)) begin
			$display("case %0d: instruction count %0d is out of range", case_id, v);
			aborted = 1'b1;
		end else if (got_case) begin
			n = v;
			for (int i = 0; i < n; i++) begin
				read_value(v, ok);
				all_ok &= ok;
				dest[i] = RW'(v);
				read_value(v, ok);
				all_ok &= ok;
				val[i] = 32'(v);
				read_value(v, ok);
				all_ok &= ok;
				hlt[i] = v[0];
			end
			for (int i = 0; i < n; i++) begin
				read_value(v, ok);
				all_ok &= ok;
				order[i] = v;
			end
			if (!all_ok) begin
				$display("case %0d: case file ends in the middle of a case", case_id);
				aborted = 1'b1;
			end
			// nothing younger than the first halt commits
			expected = n;
			for (int i = n - 1; i >= 0; i--) begin
				if (hlt[i])
					expected = i + 1;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reset and commit checks
	////////////////////////////////////////////////////////////////////////////

	task automatic apply_reset();
		@(posedge clock);
		#2;
		reset = 1'b1;
		drive_idle();
		repeat (8) @(posedge clock);
		#2;
		reset = 1'b0;
		@(negedge clock);
		// quiet outputs straight out of reset
		compare_value("commit_valid", 32'(commit_valid), 32'd0);
		compare_value("commit_wr_en", 32'(commit_wr_en), 32'd0);
		compare_value("error_status", 32'(error_status), 32'd0);
	endtask

	// one commit cycle against program order
	task automatic check_commits();
		int idx;
		bit exp_en;
		bit empty_seen;
		empty_seen = 1'b0;
		for (int s = 0; s < W; s++) begin
			if (!commit_valid[s]) begin
				empty_seen = 1'b1;
				compare_value("commit_wr_en", 32'(commit_wr_en[s]), 32'd0);
			end else if (empty_seen || committed >= expected) begin
				$display("case %0d: instruction committed after a halt or past the end",
					case_id);
				errors++;
			end else begin
				idx = committed;
				compare_value("commit_npc", commit_npc[s], npc_of(idx));
				compare_value("commit_wr_data", commit_wr_data[s], val[idx]);
				compare_value("commit_wr_idx", 32'(commit_wr_idx[s]), 32'(dest[idx]));
				// zero register is never written
				// only the youngest slot per destination writes
				exp_en = dest[idx] != RW'(`ZERO_REG);
				for (int t = s + 1; t < W; t++) begin
					if (commit_valid[t] && idx + t - s < n && dest[idx + t - s] == dest[idx])
						exp_en = 1'b0;
				end
				compare_value("commit_wr_en", 32'(commit_wr_en[s]), 32'(exp_en));
				if (hlt[idx])
					halted = 1'b1;
				committed++;
			end
		end
		// sticky once the halt is out
		compare_value("error_status", 32'(error_status), 32'(halted));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// one case with dispatch and completion interleaved
	////////////////////////////////////////////////////////////////////////////

	task automatic run_case(output bit timed_out);
		int accepted;
		int pending;
		int comp_pos;
		int gap;
		int req;
		int cycles;
		int idx;
		int slot;
		bit short_seen;
		accepted = 0;
		pending = 0;
		comp_pos = 0;
		gap = 0;
		cycles = 0;
		short_seen = 1'b0;
		committed = 0;
		halted = 1'b0;
		while ((comp_pos < n || committed < expected) && cycles < LIMIT) begin
			@(posedge clock);
			#2;
			cycles++;
			// group sampled last cycle was written at this edge
			accepted += pending;
			pending = 0;
			drive_idle();
			// one completion per cycle on rotating slots with random idle gaps
			if (gap > 0)
				gap--;
			else if (comp_pos < n && order[comp_pos] < accepted) begin
				idx = order[comp_pos];
				slot = comp_pos % W;
				complete_valid[slot] = 1'b1;
				complete_tag[slot]   = tag[idx];
				complete_value[slot] = val[idx];
				complete_halt[slot]  = hlt[idx];
				comp_pos++;
				gap = int'($urandom % 3);
			end
			// offer the oldest instructions not yet taken
			req = (n - accepted < W) ? n - accepted : W;
			for (int k = 0; k < req; k++) begin
				dispatch_valid[k] = 1'b1;
				dispatch_dest[k]  = dest[accepted + k];
				dispatch_npc[k]   = npc_of(accepted + k);
			end
			@(negedge clock);
			check_commits();
			if (req > 0) begin
				if (cycles == 1)
					compare_value("dispatch_num", 32'(dispatch_num), 32'(req));
				if (int'(dispatch_num) > req) begin
					$display("case %0d: dispatch_num exceeds the request", case_id);
					errors++;
				end
				if (int'(dispatch_num) < req)
					short_seen = 1'b1;
				for (int k = 0; k < int'(dispatch_num) && k < req; k++) begin
					// a new tag may not name an entry still in flight
					for (int j = committed; j < accepted + k; j++) begin
						if (tag[j] == dispatch_tag[k]) begin
							$display("case %0d: tag %0d handed out while still in flight",
								case_id, dispatch_tag[k]);
							errors++;
						end
					end
					tag[accepted + k] = dispatch_tag[k];
				end
				pending = int'(dispatch_num);
			end
		end
		timed_out = comp_pos < n || committed < expected;
		// nothing further may commit
		for (int q = 0; q < 12 && !timed_out; q++) begin
			@(posedge clock);
			#2;
			drive_idle();
			@(negedge clock);
			check_commits();
		end
		if (n > `ROB_SIZE && !short_seen) begin
			$display("case %0d: dispatch_num never fell below the request", case_id);
			errors++;
		end
	endtask

	initial begin
		bit got_case;
		bit timed_out;
		int case_errors;
		clock = 1'b0;
		reset = 1'b1;
		drive_idle();
		errors = 0;
		failed = 0;
		tests = 0;
		case_id = 0;
		aborted = 1'b0;
		void'($urandom(32'h78f58cde));
		fd = $fopen("commit_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open commit_cases.txt");
			aborted = 1'b1;
		end
		got_case = !aborted;
		while (got_case && !aborted) begin
			load_case(got_case);
			if (got_case && !aborted) begin
				case_errors = errors;
				apply_reset();
				run_case(timed_out);
				tests++;
				if (timed_out) begin
					$display("case %0d: timed out with %0d of %0d committed",
						case_id, committed, expected);
					errors++;
					aborted = 1'b1;
				end
				if (errors != case_errors)
					failed++;
				$display("case %0d: %0d instructions, %0d committed, %0d errors",
					case_id, n, committed, errors - case_errors);
				case_id++;
			end
		end
		if (fd != 0)
			$fclose(fd);
		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0 && !aborted && tests > 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule
